/* hdl/glay_consts.svh */
/*
  Constants of the graph overlay response return path
  Requestor count, buffer depths, back-pressure threshold and field widths
*/

`ifndef GLAY_CONSTS_SVH
`define GLAY_CONSTS_SVH

// ------------------------------------------------------------
// Requestor side
// ------------------------------------------------------------
`define NUM_REQUESTORS 4
`define QUEUE_DEPTH 8

// ------------------------------------------------------------
// Demux buffer, prog_full leaves 8 entries of slack
// ------------------------------------------------------------
`define RESP_FIFO_DEPTH 32
`define RESP_PROG_THRESH 24

// Response field widths
`define DATA_WIDTH 32
`define TAG_WIDTH 8
`define ROUTE_WIDTH 8

`endif

/* hdl/glay_pkg.sv */
/*
  Graph overlay response types
  Routing word with its CU and bundle views, response payload and
  the valid-qualified packet that travels between blocks
*/

`include "glay_consts.svh"

package glay_pkg;

  // ------------------------------------------------------------
  // Routing word
  // ------------------------------------------------------------

  // Bundle level view, bundle mask in the upper nibble
  typedef struct packed {
    logic [`ROUTE_WIDTH/2-1:0] bundle_mask;
    logic [`ROUTE_WIDTH/2-1:0] lane_mask;
  } route_bundle_t;

  // Same 8 bits, decoded either as a CU mask or as a bundle view
  typedef union packed {
    logic [`ROUTE_WIDTH-1:0] cu_mask;
    route_bundle_t           bundle_view;
  } route_id_u;

  // ------------------------------------------------------------
  // Response packet
  // ------------------------------------------------------------

  // 48 bit payload, route in the top byte
  typedef struct packed {
    route_id_u             route;
    logic [`TAG_WIDTH-1:0]  tag;
    logic [`DATA_WIDTH-1:0] data;
  } memory_payload_t;

  typedef struct packed {
    logic            valid;
    memory_payload_t payload;
  } memory_packet_t;

  // Routing views must cover the same word
  localparam int ROUTE_VIEW_BITS = $bits(route_bundle_t);

endpackage : glay_pkg

/* hdl/response_fifo.sv */
/*
  Synchronous first-word-fall-through FIFO
  Circular buffer with an occupancy count, head word shown on dout
  while not empty, prog_full at or above PROG_THRESH entries
*/

`timescale 1ns/1ns

module response_fifo #(
  parameter int DEPTH       = 32,
  parameter int WIDTH       = 48,
  parameter int PROG_THRESH = 24
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic [WIDTH-1:0] din,
  input  logic             wr_en,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             empty,
  output logic             full,
  output logic             prog_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_write;
  logic             do_read;

  // Overflow and underflow requests are ignored
  assign do_write = wr_en & ~full;
  assign do_read  = rd_en & ~empty;

  // ------------------------------------------------------------
  // Storage, no reset on the data words
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (do_write) begin
      mem[wr_ptr] <= din;
    end
  end

  // ------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head word falls through
  assign dout = mem[rd_ptr];

  assign empty     = (count == '0);
  assign full      = (count == CNT_W'(DEPTH));
  assign prog_full = (count >= CNT_W'(PROG_THRESH));

endmodule : response_fifo

/* hdl/response_demux.sv */
/*
  Response demux
  Registers incoming responses, buffers routed ones in a FWFT FIFO and
  releases each head packet to all of its target requestors in one
  cycle, once every target has signalled ready. ID_LEVEL picks the
  decoded view of the routing word, 0 for CU and 1 for bundle
*/

`timescale 1ns/1ns

`include "glay_consts.svh"

module response_demux
  import glay_pkg::*;
#(
  parameter int ID_LEVEL = 0
) (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  memory_packet_t             response_in,
  input  logic [`NUM_REQUESTORS-1:0] requestor_ready,
  output memory_packet_t             response_out [`NUM_REQUESTORS-1:0],
  output logic                       response_prog_full
);

  localparam int NUM_REQ = `NUM_REQUESTORS;

  memory_packet_t        response_in_reg;
  logic [NUM_REQ-1:0]    ready_reg;

  logic                  fifo_wr_en;
  logic                  fifo_rd_en;
  logic                  fifo_empty;
  memory_payload_t       fifo_dout;

  logic [NUM_REQ-1:0]    head_mask;
  logic                  head_release;

  memory_packet_t        dout_reg;
  logic [NUM_REQ-1:0]    dout_mask_reg;

  // ------------------------------------------------------------
  // Input stage
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      response_in_reg.valid <= 1'b0;
      ready_reg             <= '0;
    end else begin
      response_in_reg.valid <= response_in.valid;
      ready_reg             <= requestor_ready;
    end
  end

  always_ff @(posedge ap_clk) begin
    response_in_reg.payload <= response_in.payload;
  end

  // Unrouted packets never enter the buffer
  assign fifo_wr_en = response_in_reg.valid & (|response_in_reg.payload.route.cu_mask);

  response_fifo #(
    .DEPTH      (`RESP_FIFO_DEPTH),
    .WIDTH      ($bits(memory_payload_t)),
    .PROG_THRESH(`RESP_PROG_THRESH)
  ) response_fifo_inst (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .din           (response_in_reg.payload),
    .wr_en         (fifo_wr_en),
    .rd_en         (fifo_rd_en),
    .dout          (fifo_dout),
    .empty         (fifo_empty),
    .full          (),
    .prog_full     (response_prog_full)
  );

  // ------------------------------------------------------------
  // Target decode of the head entry
  // ------------------------------------------------------------
  generate
    if (ID_LEVEL == 1) begin : g_bundle_view
      assign head_mask = NUM_REQ'(fifo_dout.route.bundle_view.bundle_mask);
    end else begin : g_cu_view
      assign head_mask = NUM_REQ'(fifo_dout.route.cu_mask);
    end
  endgenerate

  // Head leaves only when every target is ready in the same cycle
  assign head_release = ~fifo_empty & ((ready_reg & head_mask) == head_mask);
  assign fifo_rd_en   = head_release;

  // ------------------------------------------------------------
  // Output pipeline, two register stages after the pop
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      dout_reg.valid <= 1'b0;
    end else begin
      dout_reg.valid <= head_release;
    end
  end

  always_ff @(posedge ap_clk) begin
    dout_reg.payload <= fifo_dout;
    dout_mask_reg    <= head_mask;
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      for (int i = 0; i < NUM_REQ; i++) begin
        response_out[i].valid <= 1'b0;
      end
    end else begin
      for (int i = 0; i < NUM_REQ; i++) begin
        response_out[i].valid <= dout_reg.valid & dout_mask_reg[i];
      end
    end
  end

  // Same payload fans out to every requestor
  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < NUM_REQ; i++) begin
      response_out[i].payload <= dout_reg.payload;
    end
  end

endmodule : response_demux

/* hdl/requestor_response_queue.sv */
/*
  Requestor response queue
  Buffers packets from the demux for one requestor and hands them to
  the consumer. Ready is withheld early enough to absorb everything
  the demux pipeline may still deliver
*/

`timescale 1ns/1ns

`include "glay_consts.svh"

module requestor_response_queue
  import glay_pkg::*;
(
  input  logic           ap_clk,
  input  logic           areset_control,
  input  memory_packet_t response_in,
  input  logic           queue_pop,
  output logic           ready,
  output memory_packet_t queue_out
);

  // Demux stages between ready sample and output register
  localparam int DEMUX_LATENCY = 3;
  localparam int CNT_W         = $clog2(`QUEUE_DEPTH + 1);
  localparam int SUM_W         = CNT_W + 1;

  logic [CNT_W-1:0]         stored_count;
  logic [DEMUX_LATENCY-1:0] ready_hist;
  logic [SUM_W-1:0]         in_flight;
  logic [SUM_W-1:0]         committed;
  logic                     fifo_empty;
  logic                     pop_accept;
  memory_payload_t          fifo_dout;

  assign pop_accept = queue_pop & ~fifo_empty;

  response_fifo #(
    .DEPTH      (`QUEUE_DEPTH),
    .WIDTH      ($bits(memory_payload_t)),
    .PROG_THRESH(`QUEUE_DEPTH - DEMUX_LATENCY)
  ) queue_fifo_inst (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .din           (response_in.payload),
    .wr_en         (response_in.valid),
    .rd_en         (pop_accept),
    .dout          (fifo_dout),
    .empty         (fifo_empty),
    .full          (),
    .prog_full     ()
  );

  assign queue_out.valid   = ~fifo_empty;
  assign queue_out.payload = fifo_dout;

  // ------------------------------------------------------------
  // Credit accounting
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      stored_count <= '0;
    end else begin
      case ({response_in.valid, pop_accept})
        2'b10:   stored_count <= stored_count + 1'b1;
        2'b01:   stored_count <= stored_count - 1'b1;
        default: stored_count <= stored_count;
      endcase
    end
  end

  // Every ready still in the pipe may turn into an arrival,
  // current ready included
  always_comb begin
    in_flight = SUM_W'(ready);
    for (int i = 0; i < DEMUX_LATENCY; i++) begin
      in_flight = in_flight + SUM_W'(ready_hist[i]);
    end
  end

  assign committed = SUM_W'(stored_count) + in_flight;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ready      <= 1'b0;
      ready_hist <= '0;
    end else begin
      ready      <= (committed < SUM_W'(`QUEUE_DEPTH - DEMUX_LATENCY));
      ready_hist <= {ready_hist[DEMUX_LATENCY-2:0], ready};
    end
  end

endmodule : requestor_response_queue

/* hdl/memory_response_path.sv */
/*
  Memory response return path
  Response demux at CU level feeding one queue per requestor
*/

`timescale 1ns/1ns

`include "glay_consts.svh"

module memory_response_path
  import glay_pkg::*;
(
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  memory_packet_t             response_in,
  input  logic [`NUM_REQUESTORS-1:0] queue_pop,
  output memory_packet_t             queue_out [`NUM_REQUESTORS-1:0],
  output logic                       response_prog_full
);

  memory_packet_t              demux_out [`NUM_REQUESTORS-1:0];
  logic [`NUM_REQUESTORS-1:0]  requestor_ready;

  // ------------------------------------------------------------
  // Demux, whole routing word as CU mask
  // ------------------------------------------------------------
  response_demux #(
    .ID_LEVEL(0)
  ) response_demux_inst (
    .ap_clk            (ap_clk),
    .areset_control    (areset_control),
    .response_in       (response_in),
    .requestor_ready   (requestor_ready),
    .response_out      (demux_out),
    .response_prog_full(response_prog_full)
  );

  // ------------------------------------------------------------
  // One queue per requestor
  // ------------------------------------------------------------
  generate
    for (genvar i = 0; i < `NUM_REQUESTORS; i++) begin : g_queue
      requestor_response_queue requestor_response_queue_inst (
        .ap_clk        (ap_clk),
        .areset_control(areset_control),
        .response_in   (demux_out[i]),
        .queue_pop     (queue_pop[i]),
        .ready         (requestor_ready[i]),
        .queue_out     (queue_out[i])
      );
    end
  endgenerate

endmodule : memory_response_path

/* verification/memory_response_path_sva.sv */
/*
  Assertions on the memory response return path ports
  Idle outputs after reset, heads held until popped, and input traffic
  that stops while the demux buffer reports prog_full
*/

`timescale 1ns/1ns

`include "glay_consts.svh"

module memory_response_path_sva
  import glay_pkg::*;
(
  input logic                       ap_clk,
  input logic                       areset_control,
  input memory_packet_t             response_in,
  input logic [`NUM_REQUESTORS-1:0] queue_pop,
  input memory_packet_t             queue_out [`NUM_REQUESTORS-1:0],
  input logic                       response_prog_full
);

  logic [`NUM_REQUESTORS-1:0] out_valid;
  int                         assertion_failures = 0;

  always_comb begin
    for (int i = 0; i < `NUM_REQUESTORS; i++) begin
      out_valid[i] = queue_out[i].valid;
    end
  end

  // Nothing presented in the first cycle after reset
  assert property (@(posedge ap_clk) $fell(areset_control) |-> (out_valid == '0))
    else begin
      $error("queue output valid in the first cycle after reset");
      assertion_failures++;
    end

  // A presented head stays until the consumer pops it
  assert property (@(posedge ap_clk) disable iff (areset_control)
    ($past(out_valid & ~queue_pop) & ~out_valid) == '0)
    else begin
      $error("queue output valid dropped without a pop");
      assertion_failures++;
    end

  // Memory port stops once prog_full was seen
  assert property (@(posedge ap_clk) disable iff (areset_control)
    $past(response_prog_full) |-> !response_in.valid)
    else begin
      $error("response sent while prog_full was high");
      assertion_failures++;
    end

endmodule : memory_response_path_sva

bind memory_response_path memory_response_path_sva memory_response_path_sva_inst (
  .ap_clk            (ap_clk),
  .areset_control    (areset_control),
  .response_in       (response_in),
  .queue_pop         (queue_pop),
  .queue_out         (queue_out),
  .response_prog_full(response_prog_full)
);

/* verification/memory_response_path_tb.sv */
/*
  Testbench of the memory response return path
  Random one-hot, broadcast and unrouted responses with random consumer
  pops, per requestor compare against a reference model, mid-run reset
*/

`timescale 1ns/1ns

`include "glay_consts.svh"

module memory_response_path_tb
  import glay_pkg::*;
();

  localparam int NUM_REQ = `NUM_REQUESTORS;
  localparam int HIGH_W  = `ROUTE_WIDTH - NUM_REQ;
  // Single, broadcast, drop, back-pressure, reset (before and after)
  localparam int TOTAL_PACKETS = 40 + 40 + 40 + 120 + 30 + 40;
  localparam int CYCLE_LIMIT   = 40 * TOTAL_PACKETS + 200;

  logic               ap_clk = 1'b0;
  logic               areset_control = 1'b1;
  memory_packet_t     response_in = '0;
  logic [NUM_REQ-1:0] queue_pop = '0;
  memory_packet_t     queue_out [NUM_REQ-1:0];
  logic               response_prog_full;

  memory_payload_t exp_q [NUM_REQ][$];
  string           current_test = "reset";
  int              pop_weight = 6;
  int              errors = 0;
  int              test_errors_start = 0;
  int              checked = 0;
  int              sent = 0;
  int              tests_run = 0;
  int              tests_failed = 0;
  int              cycle_count = 0;
  int              sva_errors = 0;

  always #10 ap_clk = ~ap_clk;

  memory_response_path memory_response_path_inst (
    .ap_clk            (ap_clk),
    .areset_control    (areset_control),
    .response_in       (response_in),
    .queue_pop         (queue_pop),
    .queue_out         (queue_out),
    .response_prog_full(response_prog_full)
  );

  // ------------------------------------------------------------
  // Reference model and stimulus helpers
  // ------------------------------------------------------------

  // Requestors named by the low bits of the CU view
  function automatic logic [NUM_REQ-1:0] expected_targets(input memory_payload_t pl);
    return pl.route.cu_mask[NUM_REQ-1:0];
  endfunction

  // Kind 0 one-hot, 1 at least two targets, 2 unrouted, else any routed
  function automatic memory_payload_t make_payload(input int kind);
    memory_payload_t    pl;
    logic [NUM_REQ-1:0] low;
    low = '0;
    case (kind)
      0: low = NUM_REQ'(1) << ($urandom % NUM_REQ);
      1: while ($countones(low) < 2) low = NUM_REQ'($urandom);
      2: low = '0;
      default: while (low == '0) low = NUM_REQ'($urandom);
    endcase
    // Upper route bits are noise for the CU view
    pl.route.cu_mask = {HIGH_W'($urandom), low};
    pl.tag           = `TAG_WIDTH'(sent);
    pl.data          = $urandom;
    return pl;
  endfunction

  task automatic send_packet(input int kind);
    memory_payload_t    pl;
    logic [NUM_REQ-1:0] targets;
    pl      = make_payload(kind);
    targets = expected_targets(pl);
    @(posedge ap_clk);
    // Hold off while the demux buffer is nearly full
    while (response_prog_full) begin
      response_in.valid <= 1'b0;
      @(posedge ap_clk);
    end
    response_in <= {1'b1, pl};
    for (int i = 0; i < NUM_REQ; i++) begin
      if (targets[i]) exp_q[i].push_back(pl);
    end
    sent++;
  endtask

  function automatic int pending();
    int total;
    total = 0;
    for (int i = 0; i < NUM_REQ; i++) total += exp_q[i].size();
    return total;
  endfunction

  task automatic check_outputs_idle();
    for (int i = 0; i < NUM_REQ; i++) begin
      assert (!queue_out[i].valid) else begin
        $display("Error in %s: requestor %0d output is valid while it should be idle",
                 current_test, i);
        errors++;
      end
    end
    assert (!response_prog_full) else begin
      $display("Error in %s: prog_full is high with the path idle", current_test);
      errors++;
    end
  endtask

  task automatic start_test(input string name, input int weight);
    current_test      = name;
    pop_weight        <= weight;
    test_errors_start = errors;
  endtask

  task automatic finish_test();
    @(posedge ap_clk);
    response_in.valid <= 1'b0;
    while (pending() != 0) @(posedge ap_clk);
    // Nothing else may show up in a quiet period
    repeat (10) @(posedge ap_clk);
    check_outputs_idle();
    tests_run++;
    if (errors == test_errors_start) begin
      $display("Test %s passed", current_test);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", current_test, errors - test_errors_start);
    end
  endtask

  // ------------------------------------------------------------
  // Consumers and compare
  // ------------------------------------------------------------
  function automatic void check_delivery(input int req, input memory_payload_t got);
    memory_payload_t want;
    assert (exp_q[req].size() > 0) else begin
      $display("Error in %s: requestor %0d delivered a packet that was never sent to it",
               current_test, req);
      errors++;
    end
    if (exp_q[req].size() > 0) begin
      want = exp_q[req].pop_front();
      checked++;
      assert (got == want) else begin
        $display("[FAIL] %s: requestor %0d expected %h actual %h", current_test, req, want, got);
        errors++;
      end
    end
  endfunction

  always @(posedge ap_clk) begin
    if (areset_control) begin
      queue_pop <= '0;
    end else begin
      for (int i = 0; i < NUM_REQ; i++) begin
        if (queue_pop[i] && queue_out[i].valid) check_delivery(i, queue_out[i].payload);
        queue_pop[i] <= (($urandom % 8) < pop_weight);
      end
    end
  end

  always @(posedge ap_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Run timed out after %0d cycles in test %s", cycle_count, current_test);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(53));
    repeat (8) @(posedge ap_clk);
    areset_control <= 1'b0;
    @(posedge ap_clk);
    check_outputs_idle();

    start_test("single_target", 6);
    repeat (40) send_packet(0);
    finish_test();

    start_test("broadcast", 6);
    repeat (40) send_packet(1);
    finish_test();

    start_test("drop_unrouted", 6);
    repeat (20) begin
      send_packet(2);
      send_packet(3);
    end
    finish_test();

    start_test("order_backpressure", 1);
    repeat (120) send_packet(3);
    finish_test();

    // Reset with packets still queued, then fresh traffic
    start_test("mid_run_reset", 2);
    repeat (30) send_packet(3);
    @(posedge ap_clk);
    areset_control    <= 1'b1;
    response_in.valid <= 1'b0;
    repeat (8) @(posedge ap_clk);
    for (int i = 0; i < NUM_REQ; i++) exp_q[i].delete();
    areset_control <= 1'b0;
    @(posedge ap_clk);
    check_outputs_idle();
    pop_weight <= 6;
    repeat (40) send_packet(3);
    finish_test();

    sva_errors = memory_response_path_inst.memory_response_path_sva_inst.assertion_failures;
    $display(
      "Summary: %0d tests, %0d failed, %0d sent, %0d checked, %0d errors, %0d assertion failures",
      tests_run, tests_failed, sent, checked, errors, sva_errors);
    if (errors == 0 && sva_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : memory_response_path_tb

/* sources.f */
+incdir+hdl
hdl/glay_pkg.sv
hdl/response_fifo.sv
hdl/response_demux.sv
hdl/requestor_response_queue.sv
hdl/memory_response_path.sv
verification/memory_response_path_sva.sv
verification/memory_response_path_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory response path testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=memory_response_path_tb
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" --Mdir "$BUILD_DIR" -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running past assertion errors so the testbench can report them
"./$BUILD_DIR/V$TOP" +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
